/* verilog/montmul_params.svh */
// Montgomery multiplier sizing, word width and word count shared by all blocks
`ifndef MONTMUL_PARAMS_SVH
`define MONTMUL_PARAMS_SVH

// ------------------------------------------------------------
// Word geometry
// ------------------------------------------------------------

// Bits per word, one processing element handles one word
`define MONTMUL_RADIX 8

// Words per operand, also the number of processing elements
`define MONTMUL_WORDS 4

// Full operand width, R = 2**MONTMUL_WIDTH
`define MONTMUL_WIDTH (`MONTMUL_RADIX * `MONTMUL_WORDS)

`endif

/* verilog/montmul_pkg.sv */
// Montgomery multiplier types, word and carry vectors, request struct and feeder FSM states
`default_nettype none

`include "montmul_params.svh"

package montmul_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------

    // One word: s words, a words, quotient m and p_inv
    typedef logic [`MONTMUL_RADIX-1:0] word_t;

    // Local carry of an element, one bit wider than a word
    typedef logic [`MONTMUL_RADIX:0] carry_t;

    // Full operand: a, b, p and the final result
    typedef logic [`MONTMUL_WIDTH-1:0] operand_t;

    // Resolved sum before the conditional subtraction, below 2p
    typedef logic [`MONTMUL_WIDTH:0] result_t;

    // ------------------------------------------------------------
    // Request payload
    // ------------------------------------------------------------

    // p must be odd; p_inv is -p^-1 mod 2**RADIX
    typedef struct packed {
        operand_t a;
        operand_t b;
        operand_t p;
        word_t    p_inv;
    } montmul_req_t;

    // Feeder sequencing
    // idle waits for a request, step runs the clear and accumulate cycles,
    // drain waits for the result to leave the collector
    typedef enum logic [1:0] {
        idle,
        step,
        drain
    } feeder_state_t;

endpackage

`default_nettype wire

/* verilog/montmul_operand_feeder.sv */
// Montgomery operand feeder, accepts a request, steps the a words and forms each quotient word
`timescale 1ns/1ps
`default_nettype none

`include "montmul_params.svh"

module montmul_operand_feeder (
    input  wire                          clk,
    input  wire                          reset_n,

    // Request port
    input  wire                          req_valid,
    output logic                         req_ready,
    input  wire montmul_pkg::montmul_req_t req,

    // State of element 0, needed for the quotient
    input  wire montmul_pkg::word_t      s0,
    input  wire montmul_pkg::carry_t     c0,
    input  wire                          release_pulse,

    // Row control
    output logic                         start,
    output logic                         step,
    output logic                         done,

    // Row data
    output montmul_pkg::word_t           a_word,
    output montmul_pkg::word_t           m_word,
    output montmul_pkg::operand_t        b_op,
    output montmul_pkg::operand_t        p_op
);

    // Counter covers the clear cycle plus WORDS steps
    localparam int CNT_W = $clog2(`MONTMUL_WORDS + 1);

    montmul_pkg::feeder_state_t state_q;
    logic [CNT_W-1:0]           cnt_q;
    logic                       accept;

    // Held operands
    montmul_pkg::operand_t      a_q;
    montmul_pkg::word_t         p_inv_q;
    montmul_pkg::word_t         low_sum;

    // ------------------------------------------------------------
    // Handshake and row control
    // ------------------------------------------------------------
    assign req_ready = (state_q == montmul_pkg::idle);
    assign accept    = req_valid & req_ready;

    // First cycle in step clears the row, the rest accumulate
    assign start = (state_q == montmul_pkg::step) && (cnt_q == '0);
    assign step  = (state_q == montmul_pkg::step) && (cnt_q != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= montmul_pkg::idle;
            cnt_q   <= '0;
            done    <= 1'b0;
        end else begin
            // done is a single-cycle pulse
            done <= 1'b0;
            case (state_q)
                montmul_pkg::idle: begin
                    if (accept) begin
                        state_q <= montmul_pkg::step;
                        cnt_q   <= '0;
                    end
                end
                montmul_pkg::step: begin
                    // Last accumulate cycle, hand over to the collector
                    if (cnt_q == CNT_W'(`MONTMUL_WORDS)) begin
                        state_q <= montmul_pkg::drain;
                        done    <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                montmul_pkg::drain: begin
                    // Wait until the response has left
                    if (release_pulse) begin
                        state_q <= montmul_pkg::idle;
                    end
                end
                default: begin
                    state_q <= montmul_pkg::idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Operand registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q     <= req.a;
            b_op    <= req.b;
            p_op    <= req.p;
            p_inv_q <= req.p_inv;
        end else if (step) begin
            // Next a word moves into the low position
            a_q <= a_q >> `MONTMUL_RADIX;
        end
    end

    assign a_word = a_q[`MONTMUL_RADIX-1:0];

    // ------------------------------------------------------------
    // Quotient word
    // ------------------------------------------------------------
    // Low word of the weight-0 column, only mod 2**RADIX matters
    assign low_sum = montmul_pkg::word_t'(s0 + c0 + a_word * b_op[`MONTMUL_RADIX-1:0]);

    // m makes the weight-0 column a multiple of the word base
    assign m_word  = low_sum * p_inv_q;

endmodule

`default_nettype wire

/* verilog/montmul_pe.sv */
// Montgomery processing element, multiply-accumulates one b word and one p word with a local carry
`timescale 1ns/1ps
`default_nettype none

`include "montmul_params.svh"

module montmul_pe (
    input  wire                      clk,
    input  wire                      reset_n,

    // Control from the feeder
    input  wire                      start,
    input  wire                      step,

    // Broadcast and owned words
    input  wire montmul_pkg::word_t  a_word,
    input  wire montmul_pkg::word_t  m_word,
    input  wire montmul_pkg::word_t  b_word,
    input  wire montmul_pkg::word_t  p_word,

    // Low word from the element above
    input  wire montmul_pkg::word_t  s_in,

    output montmul_pkg::word_t       s_out,
    output montmul_pkg::carry_t      c_out
);

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    logic [2*`MONTMUL_RADIX-1:0] prod_ab;
    logic [2*`MONTMUL_RADIX-1:0] prod_mp;

    // Sum stays below 2*W**2, one bit over two words
    logic [2*`MONTMUL_RADIX:0]   acc;

    assign prod_ab = a_word * b_word;
    assign prod_mp = m_word * p_word;

    // Own carry stays here, the incoming s already dropped one word in weight
    assign acc = prod_ab + prod_mp + s_in + c_out;

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s_out <= '0;
            c_out <= '0;
        end else if (start) begin
            // Clear before a new product
            s_out <= '0;
            c_out <= '0;
        end else if (step) begin
            // Low word moves down next step, high part is the new carry
            s_out <= acc[`MONTMUL_RADIX-1:0];
            c_out <= acc[2*`MONTMUL_RADIX:`MONTMUL_RADIX];
        end
    end

endmodule

`default_nettype wire

/* verilog/montmul_result_collector.sv */
// Montgomery result collector, resolves the redundant row sum, reduces below p and holds the response
`timescale 1ns/1ps
`default_nettype none

`include "montmul_params.svh"

module montmul_result_collector (
    input  wire                                          clk,
    input  wire                                          reset_n,

    // Row finished
    input  wire                                          done,

    // Row state, word j at index j
    input  wire montmul_pkg::operand_t                   s_row,
    input  wire montmul_pkg::carry_t [`MONTMUL_WORDS-1:0] c_row,
    input  wire montmul_pkg::operand_t                   p_op,

    // Tells the feeder the result has left
    output logic                                         release_pulse,

    // Response port
    output logic                                         resp_valid,
    input  wire                                          resp_ready,
    output montmul_pkg::operand_t                        resp
);

    montmul_pkg::result_t  sum;
    montmul_pkg::result_t  p_ext;
    montmul_pkg::operand_t reduced;
    logic                  ge_p;

    // ------------------------------------------------------------
    // Carry resolution
    // ------------------------------------------------------------
    // Element j's s word counts at weight j-1 once the last step is done,
    // so the whole s row drops one word and element 0's word is discarded.
    // The carries count at the weight of their own element.
    always_comb begin
        sum = montmul_pkg::result_t'(s_row >> `MONTMUL_RADIX);
        for (int j = 0; j < `MONTMUL_WORDS; j++) begin
            sum = sum + (montmul_pkg::result_t'(c_row[j]) << (j * `MONTMUL_RADIX));
        end
    end

    // ------------------------------------------------------------
    // Final reduction
    // ------------------------------------------------------------
    // Sum is below 2p, one subtraction is enough
    assign p_ext   = {1'b0, p_op};
    assign ge_p    = (sum >= p_ext);
    assign reduced = montmul_pkg::operand_t'(ge_p ? sum - p_ext : sum);

    // ------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------
    assign release_pulse = resp_valid & resp_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            resp_valid <= 1'b0;
        end else if (done) begin
            resp_valid <= 1'b1;
        end else if (release_pulse) begin
            resp_valid <= 1'b0;
        end
    end

    // Held stable until the transfer, the feeder blocks new work meanwhile
    always_ff @(posedge clk) begin
        if (done) begin
            resp <= reduced;
        end
    end

endmodule

`default_nettype wire

/* verilog/montmul_top.sv */
// Montgomery multiplier top level, feeder, generated element row and result collector
`timescale 1ns/1ps
`default_nettype none

`include "montmul_params.svh"

module montmul_top (
    input  wire                            clk,
    input  wire                            reset_n,

    // Request port
    input  wire                            req_valid,
    output logic                           req_ready,
    input  wire montmul_pkg::montmul_req_t req,

    // Response port
    output logic                           resp_valid,
    input  wire                            resp_ready,
    output montmul_pkg::operand_t          resp
);

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    logic                  start;
    logic                  step;
    logic                  done;
    logic                  release_pulse;
    montmul_pkg::word_t    a_word;
    montmul_pkg::word_t    m_word;
    montmul_pkg::operand_t b_op;
    montmul_pkg::operand_t p_op;

    // s chain runs downward, the slot above the top element is zero
    wire montmul_pkg::word_t  [`MONTMUL_WORDS:0]   s_link;
    wire montmul_pkg::carry_t [`MONTMUL_WORDS-1:0] c_row;

    assign s_link[`MONTMUL_WORDS] = '0;

    // ------------------------------------------------------------
    // Operand feeder
    // ------------------------------------------------------------
    // Element 0 accumulates the s word arriving from element 1
    montmul_operand_feeder feeder_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .s0            (s_link[1]),
        .c0            (c_row[0]),
        .release_pulse (release_pulse),
        .start         (start),
        .step          (step),
        .done          (done),
        .a_word        (a_word),
        .m_word        (m_word),
        .b_op          (b_op),
        .p_op          (p_op)
    );

    // ------------------------------------------------------------
    // Element row
    // ------------------------------------------------------------
    for (genvar j = 0; j < `MONTMUL_WORDS; j++) begin : g_pe
        montmul_pe pe_inst (
            .clk     (clk),
            .reset_n (reset_n),
            .start   (start),
            .step    (step),
            .a_word  (a_word),
            .m_word  (m_word),
            .b_word  (b_op[j*`MONTMUL_RADIX +: `MONTMUL_RADIX]),
            .p_word  (p_op[j*`MONTMUL_RADIX +: `MONTMUL_RADIX]),
            .s_in    (s_link[j+1]),
            .s_out   (s_link[j]),
            .c_out   (c_row[j])
        );
    end

    // ------------------------------------------------------------
    // Result collector
    // ------------------------------------------------------------
    montmul_result_collector collector_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .done          (done),
        .s_row         (s_link[`MONTMUL_WORDS-1:0]),
        .c_row         (c_row),
        .p_op          (p_op),
        .release_pulse (release_pulse),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp)
    );

endmodule

`default_nettype wire

/* tests/montmul_tb.sv */
// Montgomery multiplier testbench checking random and edge products against a bit-serial reference
`timescale 1ns/1ps
`default_nettype none

`include "montmul_params.svh"

module montmul_tb;

    // ------------------------------------------------------------
    // Run constants
    // ------------------------------------------------------------
    localparam logic [31:0] LFSR_SEED = 32'h4ac2e552;
    localparam int NUM_EDGE       = 4;
    localparam int NUM_RANDOM     = 60;
    localparam int NUM_TESTS      = NUM_EDGE + NUM_RANDOM;
    // Random requests from this index on see back-pressure
    localparam int BP_FROM        = 30;
    localparam int LATENCY        = `MONTMUL_WORDS + 2;
    localparam int TIMEOUT_CYCLES = (`MONTMUL_WORDS + 4) * NUM_TESTS + 200;

    logic                      clk;
    logic                      reset_n;
    logic                      req_valid;
    logic                      req_ready;
    montmul_pkg::montmul_req_t req;
    logic                      resp_valid;
    logic                      resp_ready;
    montmul_pkg::operand_t     resp;

    logic [31:0]               lfsr_state = LFSR_SEED;
    int                        cycle_count = 0;
    int                        resp_count = 0;

    // Expected results, back-pressure lengths and transfer edges in request order
    montmul_pkg::operand_t     exp_q[$];
    int                        hold_q[$];
    int                        lat_q[$];

    montmul_top montmul_top_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Rising edge count sampled on falling edges only
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output montmul_pkg::operand_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[`MONTMUL_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    // -p^-1 mod 2**RADIX by Newton iteration for odd p
    function automatic montmul_pkg::word_t neg_inverse(input montmul_pkg::word_t p0);
        montmul_pkg::word_t inv;
        inv = p0;
        repeat (6) inv = inv * (montmul_pkg::word_t'(2) - p0 * inv);
        return montmul_pkg::word_t'(-inv);
    endfunction

    // R mod p with R = 2**WIDTH
    function automatic montmul_pkg::operand_t r_mod_p(input montmul_pkg::operand_t p);
        montmul_pkg::result_t r;
        r = '0;
        r[`MONTMUL_WIDTH] = 1'b1;
        return montmul_pkg::operand_t'(r % {1'b0, p});
    endfunction

    // Bit-serial Montgomery product a*b*R^-1 mod p
    function automatic montmul_pkg::operand_t montmul_ref(input montmul_pkg::operand_t a,
                                                          input montmul_pkg::operand_t b,
                                                          input montmul_pkg::operand_t p);
        logic [`MONTMUL_WIDTH+1:0] t;
        t = '0;
        for (int i = 0; i < `MONTMUL_WIDTH; i++) begin
            if (a[i])
                t = t + b;
            // Make t even so the halving is exact
            if (t[0])
                t = t + p;
            t = t >> 1;
        end
        if (t >= p)
            t = t - p;
        return montmul_pkg::operand_t'(t);
    endfunction

    // Odd modulus with its top bit set and a and b below it
    task automatic random_request(output montmul_pkg::montmul_req_t r);
        montmul_pkg::operand_t p;
        montmul_pkg::operand_t a;
        montmul_pkg::operand_t b;
        draw_bits(`MONTMUL_WIDTH, p);
        p[`MONTMUL_WIDTH-1] = 1'b1;
        p[0] = 1'b1;
        draw_bits(`MONTMUL_WIDTH, a);
        draw_bits(`MONTMUL_WIDTH, b);
        r.p     = p;
        r.a     = a % p;
        r.b     = b % p;
        r.p_inv = neg_inverse(p[`MONTMUL_RADIX-1:0]);
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_result(input montmul_pkg::operand_t got,
                                input montmul_pkg::operand_t expected,
                                input string what);
        if (got !== expected)
            stop_run($sformatf("Fail %0t: %s got %h expected %h", $time, what, got, expected));
    endtask

    task automatic check_latency(input int got, input int expected);
        if (got != expected)
            stop_run($sformatf("Fail %0t: latency %0d cycles, expected %0d",
                               $time, got, expected));
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic send_request(input montmul_pkg::montmul_req_t r,
                                input montmul_pkg::operand_t expected,
                                input int hold);
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(expected);
        hold_q.push_back(hold);
        while (!req_ready) @(negedge clk);
        // Transfer happens on the coming rising edge
        lat_q.push_back(cycle_count + 1);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Driver
    // ------------------------------------------------------------
    initial begin
        montmul_pkg::montmul_req_t r;
        montmul_pkg::operand_t     v;
        reset_n    = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Idle outputs right after reset
        if (req_ready !== 1'b1)
            stop_run("req_ready is not high after reset");
        if (resp_valid !== 1'b0)
            stop_run("resp_valid is not low after reset");

        // Edge operands with the first one in the first cycle out of reset
        random_request(r);
        r.a = '0;
        send_request(r, '0, 0);
        random_request(r);
        r.b = '0;
        send_request(r, '0, 0);
        // R mod p is the Montgomery form of one
        random_request(r);
        r.a = r_mod_p(r.p);
        send_request(r, r.b, 0);
        // Largest operands where the result tends to need the final subtraction
        random_request(r);
        r.a = r.p - 1'b1;
        r.b = r.p - 1'b1;
        send_request(r, montmul_ref(r.a, r.b, r.p), 0);

        // Random products with back-pressure in the second half
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_request(r);
            if (i >= BP_FROM) begin
                draw_bits(2, v);
                send_request(r, montmul_ref(r.a, r.b, r.p), int'(v) + 1);
            end else begin
                send_request(r, montmul_ref(r.a, r.b, r.p), 0);
            end
        end

        while (resp_count < NUM_TESTS) @(negedge clk);
        // Back in idle once the last response has left
        @(negedge clk);
        if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
            stop_run("DUT did not return to idle after the last response");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Response monitor
    // ------------------------------------------------------------
    initial begin
        montmul_pkg::operand_t held_resp;
        logic                  valid_seen;
        int                    hold_left;
        valid_seen = 1'b0;
        hold_left  = 0;
        @(posedge reset_n);
        forever begin
            @(negedge clk);
            if (resp_valid) begin
                if (!valid_seen) begin
                    // First cycle of this response
                    valid_seen = 1'b1;
                    if (lat_q.size() == 0 || hold_q.size() == 0) begin
                        stop_run("resp_valid rose with no request outstanding");
                    end else begin
                        check_latency(cycle_count - lat_q.pop_front(), LATENCY);
                        hold_left = hold_q.pop_front();
                    end
                    held_resp = resp;
                end
                check_result(resp, held_resp, "resp moved while waiting");
                if (req_ready)
                    stop_run("req_ready was high while a response was waiting");
                if (hold_left > 0) begin
                    resp_ready = 1'b0;
                    hold_left--;
                end else begin
                    // Transfer on the coming rising edge
                    resp_ready = 1'b1;
                    check_result(resp, exp_q.pop_front(), "product");
                    resp_count++;
                    valid_seen = 1'b0;
                end
            end else begin
                if (valid_seen)
                    stop_run("resp_valid dropped before the response was taken");
                resp_ready = 1'b0;
            end
        end
    end

    // Guard against a stalled handshake
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) @(negedge clk);
        stop_run($sformatf("Timeout after %0d cycles with %0d of %0d responses received",
                           TIMEOUT_CYCLES, resp_count, NUM_TESTS));
    end

endmodule

`default_nettype wire

/* montmul.f */
+incdir+verilog
verilog/montmul_pkg.sv
verilog/montmul_operand_feeder.sv
verilog/montmul_pe.sv
verilog/montmul_result_collector.sv
verilog/montmul_top.sv
tests/montmul_tb.sv

/* Bender.yml */
package:
  name: montmul

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/montmul_pkg.sv
      - verilog/montmul_operand_feeder.sv
      - verilog/montmul_pe.sv
      - verilog/montmul_result_collector.sv
      - verilog/montmul_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/montmul_tb.sv
